// File: Bender.yml
package:
  name: uart_io

sources:
  - uart_io_pkg.sv
  - uart_rx.sv
  - cmd_assembler.sv
  - fabric_requester.sv
  - reply_serializer.sv
  - uart_tx.sv
  - uart_io.sv
  - target: simulation
    files:
      - tb_uart_io.sv

// File: cmd_assembler.sv
// frame parser; a new frame may only complete while an earlier command is pending, not two
`timescale 1ns/1ps

module cmd_assembler
  import uart_io_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     byte_strobe,
  input  t_rx_byte rx_byte,
  output logic     cmd_valid,
  output t_cmd     cmd,
  input  logic     cmd_accept,
  output logic     interrupt
);

  typedef enum logic [1:0] {st_opcode, st_address, st_data} t_state;

  t_state      state;
  logic [1:0]  byte_cnt;
  t_opcode     op_q;
  logic [31:0] addr_q;
  logic [31:0] data_q;
  logic [31:0] addr_next;
  logic [31:0] data_next;
  logic        pending;   // finished frame waiting behind an unaccepted command
  logic        bad_byte;
  logic        last_byte;
  logic        load_now;
  t_cmd        frame_cmd;

  assign addr_next = {addr_q[23:0], rx_byte.data}; // msb first
  assign data_next = {data_q[23:0], rx_byte.data};

  always_comb begin
    bad_byte = byte_strobe && (rx_byte.frame_err ||
               (state == st_opcode && rx_byte.data != FRAME_WR && rx_byte.data != FRAME_RD));
    last_byte = byte_strobe && !rx_byte.frame_err && byte_cnt == 2'd3 &&
                ((state == st_address && op_q == RD) || state == st_data);
    load_now = last_byte && (!cmd_valid || cmd_accept);
    // fold the current byte in so cmd_valid can rise right after the last strobe
    frame_cmd.opcode  = op_q;
    frame_cmd.address = (state == st_address) ? addr_next : addr_q;
    frame_cmd.data    = (state == st_data) ? data_next : data_q;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_opcode;
      byte_cnt  <= '0;
      cmd_valid <= 1'b0;
      pending   <= 1'b0;
      interrupt <= 1'b0;
    end else begin
      interrupt <= bad_byte;
      if (bad_byte) begin
        state    <= st_opcode; // resync on the next byte
        byte_cnt <= '0;
      end else if (byte_strobe) begin
        case (state)
          st_opcode: begin
            state    <= st_address;
            byte_cnt <= '0;
          end
          st_address: begin
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == 2'd3) state <= (op_q == WR) ? st_data : st_opcode;
          end
          st_data: begin
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == 2'd3) state <= st_opcode;
          end
          default: state <= st_opcode;
        endcase
      end
      if (load_now) begin
        cmd_valid <= 1'b1;
      end else if (last_byte) begin
        pending <= 1'b1;
      end else if (cmd_accept) begin
        cmd_valid <= pending; // hand over the queued frame
        pending   <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (byte_strobe && !bad_byte) begin
      case (state)
        st_opcode:  op_q   <= (rx_byte.data == FRAME_WR) ? WR : RD;
        st_address: addr_q <= addr_next;
        st_data:    data_q <= data_next;
        default:    op_q   <= op_q;
      endcase
    end
    if (load_now) cmd <= frame_cmd;
    else if (cmd_accept && pending) cmd <= '{opcode: op_q, address: addr_q, data: data_q};
  end

endmodule

// File: fabric_requester.sv
// single outstanding fabric transfer; a response in the acceptance cycle itself is not seen
`timescale 1ns/1ps

module fabric_requester
  import uart_io_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        cmd_valid,
  input  t_cmd        cmd,
  output logic        cmd_accept,
  output logic        req_valid,
  output t_opcode     req_opcode,
  output logic [31:0] req_address,
  output logic [31:0] req_data,
  input  logic        rsp_valid,
  input  t_opcode     rsp_opcode,
  input  logic [31:0] rsp_data,
  input  logic        rsp_stall,
  output logic        reply_strobe,
  output t_reply      reply
);

  typedef enum logic [1:0] {st_idle, st_request, st_wait_rsp} t_state;

  t_state  state;
  t_opcode expect_op;
  logic    rsp_match;

  // writes are answered with WR, reads with RD_RSP
  assign expect_op = (req_opcode == WR) ? WR : RD_RSP;
  assign rsp_match = rsp_valid && (rsp_opcode == expect_op);

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= st_idle;
      cmd_accept   <= 1'b0;
      req_valid    <= 1'b0;
      reply_strobe <= 1'b0;
    end else begin
      cmd_accept   <= 1'b0;
      reply_strobe <= 1'b0;
      case (state)
        st_idle: begin
          if (cmd_valid) begin
            cmd_accept <= 1'b1;
            req_valid  <= 1'b1;
            state      <= st_request;
          end
        end
        st_request: begin
          if (!rsp_stall) begin // accepted this cycle
            req_valid <= 1'b0;
            state     <= st_wait_rsp;
          end
        end
        st_wait_rsp: begin
          if (rsp_match) begin
            reply_strobe <= 1'b1;
            state        <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // request fields stay frozen from launch until the next command
  always_ff @(posedge clk) begin
    if (state == st_idle && cmd_valid) begin
      req_opcode  <= cmd.opcode;
      req_address <= cmd.address;
      req_data    <= cmd.data;
    end
    if (state == st_wait_rsp && rsp_match) begin
      reply.write <= (req_opcode == WR);
      reply.data  <= rsp_data;
    end
  end

endmodule

// File: files.f
uart_io_pkg.sv
uart_rx.sv
cmd_assembler.sv
fabric_requester.sv
reply_serializer.sv
uart_tx.sv
uart_io.sv
tb_uart_io.sv

// File: reply_serializer.sv
// reply byte sequencer; a new reply must not arrive before the previous one has been issued
`timescale 1ns/1ps

module reply_serializer
  import uart_io_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       reply_strobe,
  input  t_reply     reply,
  output logic       tx_start,
  output logic [7:0] tx_byte,
  input  logic       tx_busy
);

  logic [31:0] shift;
  logic [2:0]  remaining; // bytes left to issue, 0 to 4

  // tx_busy rises on the same edge that takes tx_start
  assign tx_start = (remaining != 3'd0) && !tx_busy;
  assign tx_byte  = shift[31:24];

  always_ff @(posedge clk) begin
    if (rst) begin
      remaining <= '0;
    end else begin
      if (reply_strobe) remaining <= reply.write ? 3'd1 : 3'd4;
      else if (tx_start) remaining <= remaining - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reply_strobe) begin
      if (reply.write) shift <= {REPLY_ACK, 24'h0};
      else shift <= reply.data; // msb first
    end else if (tx_start) begin
      shift <= {shift[23:0], 8'h00};
    end
  end

endmodule

// File: tb_uart_io.sv
// testbench for the uart bridge; 16 clocks per bit, stops at the first mismatch
`timescale 1ns/1ps

module tb_uart_io
  import uart_io_pkg::*;
();

  localparam int clks_per_bit = 16;
  // every frame and reply byte of the run, 10 line bits each
  localparam int total_bits   = (4 * 10 + 2 * 9 + 2 + 30 * 10) * 10;
  localparam int cycle_limit  = 2 * total_bits * clks_per_bit + 2000;

  logic        clk;
  logic        rst;
  logic        rx;
  logic        tx;
  logic        interrupt;
  logic        req_valid;
  t_opcode     req_opcode;
  logic [31:0] req_address;
  logic [31:0] req_data;
  logic        rsp_valid;
  t_opcode     rsp_opcode;
  logic [31:0] rsp_data;
  logic        rsp_stall;

  logic [31:0] stall_rng;
  logic [31:0] frame_rng;
  int          cycles;
  int          irq_count;
  int          reply_count;
  logic [7:0]  exp_q[$];               // reply bytes the host expects
  logic [7:0]  got_q[$];               // bytes decoded from tx
  t_cmd        req_q[$];               // requests the fabric should see
  logic [31:0] ref_mem[logic [31:0]];  // host view of memory
  logic [31:0] mem[logic [31:0]];      // fabric model storage
  logic        holding;
  t_cmd        held;
  logic        rsp_pending;
  int          rsp_delay;
  t_opcode     rsp_op_next;
  logic [31:0] rsp_data_next;

  uart_io #(.clks_per_bit(clks_per_bit)) uart_io_i (
    .clk         (clk),
    .rst         (rst),
    .rx          (rx),
    .tx          (tx),
    .interrupt   (interrupt),
    .req_valid   (req_valid),
    .req_opcode  (req_opcode),
    .req_address (req_address),
    .req_data    (req_data),
    .rsp_valid   (rsp_valid),
    .rsp_opcode  (rsp_opcode),
    .rsp_data    (rsp_data),
    .rsp_stall   (rsp_stall)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift(inout logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // expected reply word, a write answers with one ack byte in the top position
  function automatic logic [31:0] ref_reply(input logic [7:0] op, input logic [31:0] addr);
    if (op == FRAME_WR) return {REPLY_ACK, 24'h0};
    if (ref_mem.exists(addr)) return ref_mem[addr];
    return addr ^ 32'hA5A5_A5A5; // never written
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("[ERROR] %0t ns: %s = %h, expected %h", $time, name, got, exp));
  endtask

  task automatic send_byte(input logic [7:0] b, input logic bad_stop);
    logic [9:0] bits;
    int         i;
    bits = {!bad_stop, b, 1'b0}; // stop, data lsb first, start
    for (i = 0; i < 10; i++) begin
      rx = bits[i];
      repeat (clks_per_bit) @(posedge clk);
      #1;
    end
    rx = 1'b1;
    if (bad_stop) begin
      repeat (clks_per_bit) @(posedge clk); // idle bit so the next start edge is seen
      #1;
    end
  endtask

  task automatic send_frame(input logic [7:0] op, input logic [31:0] addr,
                            input logic [31:0] data);
    logic [31:0] word;
    t_cmd        req;
    int          i;
    word = ref_reply(op, addr);
    if (op == FRAME_WR) begin
      exp_q.push_back(word[31:24]);
      ref_mem[addr] = data;
    end else begin
      for (i = 3; i >= 0; i--) exp_q.push_back(word[i*8 +: 8]);
    end
    req.opcode  = (op == FRAME_WR) ? WR : RD;
    req.address = addr;
    req.data    = data;
    req_q.push_back(req);
    send_byte(op, 1'b0);
    for (i = 3; i >= 0; i--) send_byte(addr[i*8 +: 8], 1'b0);
    if (op == FRAME_WR)
      for (i = 3; i >= 0; i--) send_byte(data[i*8 +: 8], 1'b0);
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0 || req_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    #1;
  endtask

  task automatic accept_request();
    t_cmd exp;
    if (req_q.size() == 0) stop_on_error("fabric request issued with no frame pending");
    exp = req_q.pop_front();
    check("req_opcode", req_opcode, exp.opcode);
    check("req_address", req_address, exp.address);
    if (exp.opcode == WR) begin
      check("req_data", req_data, exp.data);
      mem[req_address] = req_data;
      rsp_op_next      = WR;
      rsp_data_next    = xorshift(stall_rng); // junk, ignored for writes
    end else begin
      rsp_op_next   = RD_RSP;
      rsp_data_next = mem.exists(req_address) ? mem[req_address] : req_address ^ 32'hA5A5_A5A5;
    end
    rsp_delay   = xorshift(stall_rng) % 4; // response 1 to 4 cycles after accept
    rsp_pending = 1'b1;
  endtask

  // fabric model, samples on the edge and drives 1 ns later
  always @(posedge clk) begin
    if (rst) begin
      holding     = 1'b0;
      rsp_pending = 1'b0;
    end else if (req_valid) begin
      if (holding) begin
        check("req_opcode under stall", req_opcode, held.opcode);
        check("req_address under stall", req_address, held.address);
        check("req_data under stall", req_data, held.data);
      end
      held    = '{opcode: req_opcode, address: req_address, data: req_data};
      holding = 1'b1;
      if (!rsp_stall) begin
        holding = 1'b0;
        accept_request();
      end
    end
    #1;
    rsp_valid = 1'b0;
    rsp_stall = (xorshift(stall_rng) % 3) == 0;
    if (rsp_pending) begin
      if (rsp_delay == 0) begin
        rsp_valid   = 1'b1;
        rsp_opcode  = rsp_op_next;
        rsp_data    = rsp_data_next;
        rsp_pending = 1'b0;
      end else begin
        rsp_delay--;
      end
    end
  end

  // tx monitor, samples mid-bit on the falling clock edge
  initial begin
    logic [7:0] b;
    int         i;
    forever begin
      @(negedge clk);
      if (tx === 1'b0) begin
        repeat (clks_per_bit / 2) @(negedge clk);
        if (tx !== 1'b0) stop_on_error("tx start bit ended before mid-bit");
        for (i = 0; i < 8; i++) begin
          repeat (clks_per_bit) @(negedge clk);
          b[i] = tx;
        end
        repeat (clks_per_bit) @(negedge clk);
        check("tx stop bit", tx, 1'b1);
        got_q.push_back(b);
        reply_count++;
      end
    end
  end

  // compare decoded reply bytes with the reference
  always @(posedge clk) begin
    if (got_q.size() != 0) begin
      if (exp_q.size() == 0) stop_on_error("reply byte on tx with no reply expected");
      check("tx reply byte", got_q.pop_front(), exp_q.pop_front());
    end
  end

  always @(posedge clk) begin
    if (!rst && interrupt) irq_count++;
    cycles++;
    if (cycles > cycle_limit) stop_on_error("timeout: run did not finish within the cycle limit");
  end

  initial begin
    logic [31:0] r;
    logic [31:0] addr;
    int          n;
    int          base;
    clk         = 1'b0;
    rst         = 1'b1;
    rx          = 1'b1;
    rsp_valid   = 1'b0;
    rsp_opcode  = RD;
    rsp_data    = '0;
    rsp_stall   = 1'b0;
    stall_rng   = 32'd44;
    frame_rng   = 32'd44;
    cycles      = 0;
    irq_count   = 0;
    reply_count = 0;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
    check("tx", tx, 1'b1);
    check("req_valid", req_valid, 1'b0);
    check("interrupt", interrupt, 1'b0);

    send_frame(FRAME_WR, 32'h1000_0004, 32'hDEAD_BEEF);
    wait_idle();
    send_frame(FRAME_WR, 32'h1000_0008, 32'h0123_4567);
    wait_idle();
    send_frame(FRAME_WR, 32'h1000_0004, 32'hCAFE_F00D); // overwrite
    wait_idle();

    send_frame(FRAME_RD, 32'h1000_0004, 32'h0);
    wait_idle();
    send_frame(FRAME_RD, 32'h2000_0000, 32'h0); // default value
    wait_idle();

    send_byte(8'h33, 1'b0);     // unknown opcode
    send_byte(FRAME_WR, 1'b1);  // low stop bit
    repeat (2 * clks_per_bit) @(posedge clk);
    #1;
    check("interrupt pulses", irq_count, 2);
    send_frame(FRAME_WR, 32'h1000_000C, 32'h5A5A_0FF0);
    wait_idle();

    // next frame goes out once the first reply byte is back
    for (n = 0; n < 30; n++) begin
      r    = xorshift(frame_rng);
      addr = 32'h3000_0000 + {26'h0, r[7:4], 2'b00};
      base = reply_count;
      send_frame(r[0] ? FRAME_WR : FRAME_RD, addr, xorshift(frame_rng));
      while (reply_count == base) @(posedge clk);
      #1;
    end
    wait_idle();
    repeat (20 * clks_per_bit) @(posedge clk);
    check("total interrupt pulses", irq_count, 2);
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: uart_io.sv
// uart to fabric debug bridge top; host waits for each reply before its next frame
`timescale 1ns/1ps

module uart_io
  import uart_io_pkg::*;
#(
  parameter int clks_per_bit = 16
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        rx,
  output logic        tx,
  output logic        interrupt,
  output logic        req_valid,
  output t_opcode     req_opcode,
  output logic [31:0] req_address,
  output logic [31:0] req_data,
  input  logic        rsp_valid,
  input  t_opcode     rsp_opcode,
  input  logic [31:0] rsp_data,
  input  logic        rsp_stall
);

  logic       byte_strobe;
  t_rx_byte   rx_byte;
  logic       cmd_valid;
  logic       cmd_accept;
  t_cmd       cmd;
  logic       reply_strobe;
  t_reply     reply;
  logic       tx_start;
  logic [7:0] tx_byte;
  logic       tx_busy;

  uart_rx #(.clks_per_bit(clks_per_bit)) uart_rx_i (
    .clk         (clk),
    .rst         (rst),
    .rx          (rx),
    .byte_strobe (byte_strobe),
    .rx_byte     (rx_byte)
  );

  cmd_assembler cmd_assembler_i (
    .clk         (clk),
    .rst         (rst),
    .byte_strobe (byte_strobe),
    .rx_byte     (rx_byte),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .cmd_accept  (cmd_accept),
    .interrupt   (interrupt)
  );

  fabric_requester fabric_requester_i (
    .clk          (clk),
    .rst          (rst),
    .cmd_valid    (cmd_valid),
    .cmd          (cmd),
    .cmd_accept   (cmd_accept),
    .req_valid    (req_valid),
    .req_opcode   (req_opcode),
    .req_address  (req_address),
    .req_data     (req_data),
    .rsp_valid    (rsp_valid),
    .rsp_opcode   (rsp_opcode),
    .rsp_data     (rsp_data),
    .rsp_stall    (rsp_stall),
    .reply_strobe (reply_strobe),
    .reply        (reply)
  );

  reply_serializer reply_serializer_i (
    .clk          (clk),
    .rst          (rst),
    .reply_strobe (reply_strobe),
    .reply        (reply),
    .tx_start     (tx_start),
    .tx_byte      (tx_byte),
    .tx_busy      (tx_busy)
  );

  uart_tx #(.clks_per_bit(clks_per_bit)) uart_tx_i (
    .clk      (clk),
    .rst      (rst),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

endmodule

// File: uart_io_pkg.sv
// shared types for the uart debug bridge; fixed 8N1 framing, 32-bit address and data only
package uart_io_pkg;

  // fabric opcodes, encoding shared with the memory fabric
  typedef enum logic [1:0] {
    RD     = 2'b00,
    RD_RSP = 2'b01,
    WR     = 2'b10
  } t_opcode;

  // host frame and reply bytes
  localparam logic [7:0] FRAME_WR  = 8'h57; // 'W'
  localparam logic [7:0] FRAME_RD  = 8'h52; // 'R'
  localparam logic [7:0] REPLY_ACK = 8'h4B; // 'K'

  // one received character
  typedef struct packed {
    logic [7:0] data;
    logic       frame_err; // stop bit sampled low
  } t_rx_byte;

  // decoded host command
  typedef struct packed {
    t_opcode     opcode;
    logic [31:0] address;
    logic [31:0] data; // unused for reads
  } t_cmd;

  // completed fabric transfer
  typedef struct packed {
    logic        write;
    logic [31:0] data; // read data, unused for writes
  } t_reply;

endpackage

// File: uart_rx.sv
// 8N1 receiver, no parity; clks_per_bit must be at least 4 and the line must idle high
`timescale 1ns/1ps

module uart_rx
  import uart_io_pkg::*;
#(
  parameter int clks_per_bit = 16
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     rx,
  output logic     byte_strobe,
  output t_rx_byte rx_byte
);

  localparam int cnt_w    = $clog2(clks_per_bit);
  localparam int half_bit = clks_per_bit / 2;

  typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} t_state;

  t_state           state;
  logic [cnt_w-1:0] cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift;
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             bit_end;

  // full bit period elapsed since the last mid-bit sample
  assign bit_end = (cnt == cnt_w'(clks_per_bit - 1));

  // two-flop synchronizer plus one delay stage for edge detect
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= st_idle;
      cnt         <= '0;
      bit_idx     <= '0;
      byte_strobe <= 1'b0;
    end else begin
      byte_strobe <= 1'b0;
      cnt         <= cnt + 1'b1;
      case (state)
        st_idle: begin
          cnt <= '0;
          if (rx_prev && !rx_sync) state <= st_start; // falling edge only, not a held low
        end
        st_start: begin
          if (cnt == cnt_w'(half_bit - 1)) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? st_idle : st_data; // glitch rejected
          end
        end
        st_data: begin
          if (bit_end) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= st_stop;
          end
        end
        st_stop: begin
          if (bit_end) begin
            byte_strobe <= 1'b1;
            state       <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // data path, lsb arrives first
  always_ff @(posedge clk) begin
    if (state == st_data && bit_end) shift <= {rx_sync, shift[7:1]};
    if (state == st_stop && bit_end) begin
      rx_byte.data      <= shift;
      rx_byte.frame_err <= !rx_sync;
    end
  end

endmodule

// File: uart_tx.sv
// 8N1 transmitter, one byte at a time; tx_start is ignored while tx_busy is high
`timescale 1ns/1ps

module uart_tx #(
  parameter int clks_per_bit = 16
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx,
  output logic       tx_busy
);

  localparam int cnt_w = $clog2(clks_per_bit);

  logic [cnt_w-1:0] baud_cnt;
  logic [3:0]       bit_cnt;
  logic [9:0]       shift; // stop, data lsb first, start
  logic             bit_end;

  assign bit_end = (baud_cnt == cnt_w'(clks_per_bit - 1));
  assign tx      = shift[0]; // all ones out of reset keeps the line idle

  always_ff @(posedge clk) begin
    if (rst) begin
      shift    <= '1;
      tx_busy  <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (!tx_busy) begin
      baud_cnt <= '0;
      bit_cnt  <= '0;
      if (tx_start) begin
        shift   <= {1'b1, tx_byte, 1'b0};
        tx_busy <= 1'b1;
      end
    end else if (bit_end) begin
      baud_cnt <= '0;
      bit_cnt  <= bit_cnt + 1'b1;
      shift    <= {1'b1, shift[9:1]};
      if (bit_cnt == 4'd9) tx_busy <= 1'b0; // stop bit done
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

endmodule
